//--- Makefile
SIM      ?= verilator
TOP      ?= strided_copy_tb
FILELIST ?= strided_copy.f
OBJ_DIR  ?= obj_dir
FLAGS    ?= --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM_ARGS ?= +verilator+error+limit+100
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/nested_addr_gen.sv
`timescale 1ns/1ps

module nested_addr_gen #(
    parameter int ADDR_W = strided_copy_pkg::DEF_ADDR_W,
    parameter int ADIM   = strided_copy_pkg::DEF_ADIM
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              init_pulse,
    input  logic              addr_req,
    input  logic [ADDR_W-1:0] base,
    input  logic [ADDR_W-1:0] size[ADIM],
    input  logic [ADDR_W-1:0] stride[ADIM],
    output logic [ADDR_W-1:0] addr,
    output logic              addr_vld
);

    logic [ADDR_W-1:0] digit[ADIM];
    logic [ADDR_W-1:0] offset[ADIM];
    logic [ADDR_W-1:0] cur_digit[ADIM];
    logic [ADDR_W-1:0] cur_offset[ADIM];
    logic [ADDR_W-1:0] nxt_digit[ADIM];
    logic [ADDR_W-1:0] nxt_offset[ADIM];
    logic [ADDR_W-1:0] offset_sum;

    // Odometer step, dimension 0 runs fastest.
    always_comb begin
        logic carry;
        carry      = 1'b1;
        offset_sum = '0;
        for (int d = 0; d < ADIM; d++) begin
            cur_digit[d]  = init_pulse ? '0 : digit[d];   // Init restarts at index zero.
            cur_offset[d] = init_pulse ? '0 : offset[d];
            offset_sum    = offset_sum + cur_offset[d];
            nxt_digit[d]  = cur_digit[d];
            nxt_offset[d] = cur_offset[d];
            if (carry) begin
                if (cur_digit[d] == size[d] - 1'b1) begin
                    nxt_digit[d]  = '0;
                    nxt_offset[d] = '0;
                end else begin
                    nxt_digit[d]  = cur_digit[d] + 1'b1;
                    nxt_offset[d] = cur_offset[d] + stride[d];
                    carry         = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            digit  <= '{default: '0};
            offset <= '{default: '0};
        end else if (addr_req) begin
            digit  <= nxt_digit;
            offset <= nxt_offset;
        end else if (init_pulse) begin
            digit  <= cur_digit;
            offset <= cur_offset;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            addr     <= '0;
            addr_vld <= 1'b0;
        end else begin
            addr_vld <= addr_req;
            if (addr_req) addr <= base + offset_sum;
        end
    end

endmodule : nested_addr_gen

//--- src/read_sequencer.sv
`timescale 1ns/1ps

module read_sequencer #(
    parameter int ADDR_W = strided_copy_pkg::DEF_ADDR_W,
    parameter int ADIM   = strided_copy_pkg::DEF_ADIM
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              init_pulse,
    input  logic [ADDR_W-1:0] areq_num,
    input  logic [ADDR_W-1:0] raddr_base,
    input  logic [ADDR_W-1:0] raddr_size[ADIM],
    input  logic [ADDR_W-1:0] raddr_stride[ADIM],
    output logic [ADDR_W-1:0] raddr,
    output logic              raddr_vld
);

    strided_copy_pkg::rd_state_t state, state_nxt;

    logic [ADDR_W-1:0] req_cnt;
    logic [ADDR_W-1:0] req_max;
    logic              gen_req;
    logic [ADDR_W-1:0] gen_addr;
    logic              gen_vld;

    always_comb begin
        state_nxt = state;
        if (init_pulse) begin
            state_nxt = (areq_num != '0) ? strided_copy_pkg::RD_ISSUE : strided_copy_pkg::RD_IDLE;
        end else if (state == strided_copy_pkg::RD_ISSUE && req_cnt == req_max - 1'b1) begin
            state_nxt = strided_copy_pkg::RD_IDLE;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) state <= strided_copy_pkg::RD_IDLE;
        else          state <= state_nxt;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req_cnt <= '0;
            req_max <= '0;
        end else if (init_pulse) begin
            req_cnt <= '0;
            req_max <= areq_num;
        end else if (state == strided_copy_pkg::RD_ISSUE) begin
            req_cnt <= req_cnt + 1'b1;
        end
    end

    // Request leads the ISSUE cycle by one, keeps raddr at init + 2.
    assign gen_req = (state_nxt == strided_copy_pkg::RD_ISSUE);

    nested_addr_gen #(.ADDR_W(ADDR_W), .ADIM(ADIM)) rd_addr_gen (
        .clk        (clk),
        .reset_n    (reset_n),
        .init_pulse (init_pulse),
        .addr_req   (gen_req),
        .base       (raddr_base),
        .size       (raddr_size),
        .stride     (raddr_stride),
        .addr       (gen_addr),
        .addr_vld   (gen_vld)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            raddr     <= '0;
            raddr_vld <= 1'b0;
        end else begin
            raddr_vld <= gen_vld;
            if (gen_vld) raddr <= gen_addr;
        end
    end

endmodule : read_sequencer

//--- src/strided_copy.sv
`timescale 1ns/1ps

module strided_copy #(
    parameter int ADDR_W = strided_copy_pkg::DEF_ADDR_W,
    parameter int ADIM   = strided_copy_pkg::DEF_ADIM,
    parameter int DATA_W = strided_copy_pkg::DEF_DATA_W
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              init_pulse,
    input  logic [ADDR_W-1:0] areq_num,     // Beats per run.
    input  logic [ADDR_W-1:0] raddr_base,
    input  logic [ADDR_W-1:0] raddr_size[ADIM],
    input  logic [ADDR_W-1:0] raddr_stride[ADIM],
    input  logic [ADDR_W-1:0] waddr_base,
    input  logic [ADDR_W-1:0] waddr_size[ADIM],
    input  logic [ADDR_W-1:0] waddr_stride[ADIM],
    output logic [ADDR_W-1:0] raddr,
    output logic              raddr_vld,
    input  logic [DATA_W-1:0] rdata,
    input  logic              rdata_vld,
    output logic [ADDR_W-1:0] waddr,
    output logic [DATA_W-1:0] wdata,
    output logic              wdata_vld,
    output logic              finish
);

    read_sequencer #(.ADDR_W(ADDR_W), .ADIM(ADIM)) u_read_seq (
        .clk          (clk),
        .reset_n      (reset_n),
        .init_pulse   (init_pulse),
        .areq_num     (areq_num),
        .raddr_base   (raddr_base),
        .raddr_size   (raddr_size),
        .raddr_stride (raddr_stride),
        .raddr        (raddr),
        .raddr_vld    (raddr_vld)
    );

    // Write side is paced only by returned beats.
    write_sequencer #(.ADDR_W(ADDR_W), .ADIM(ADIM), .DATA_W(DATA_W)) u_write_seq (
        .clk          (clk),
        .reset_n      (reset_n),
        .init_pulse   (init_pulse),
        .areq_num     (areq_num),
        .waddr_base   (waddr_base),
        .waddr_size   (waddr_size),
        .waddr_stride (waddr_stride),
        .rdata        (rdata),
        .rdata_vld    (rdata_vld),
        .waddr        (waddr),
        .wdata        (wdata),
        .wdata_vld    (wdata_vld),
        .finish       (finish)
    );

endmodule : strided_copy

//--- src/strided_copy_pkg.sv
package strided_copy_pkg;

    // Defaults picked up by the top level.
    localparam int DEF_ADDR_W = 16;
    localparam int DEF_ADIM   = 3;
    localparam int DEF_DATA_W = 512;   // 64 bytes per beat.

    typedef enum logic {
        RD_IDLE  = 1'b0,   // Waiting for init_pulse.
        RD_ISSUE = 1'b1    // Issuing read requests.
    } rd_state_t;

    typedef enum logic {
        WR_IDLE = 1'b0,
        WR_RUN  = 1'b1     // Counting returned beats.
    } wr_state_t;

endpackage : strided_copy_pkg

//--- src/write_sequencer.sv
`timescale 1ns/1ps

module write_sequencer #(
    parameter int ADDR_W = strided_copy_pkg::DEF_ADDR_W,
    parameter int ADIM   = strided_copy_pkg::DEF_ADIM,
    parameter int DATA_W = strided_copy_pkg::DEF_DATA_W
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              init_pulse,
    input  logic [ADDR_W-1:0] areq_num,
    input  logic [ADDR_W-1:0] waddr_base,
    input  logic [ADDR_W-1:0] waddr_size[ADIM],
    input  logic [ADDR_W-1:0] waddr_stride[ADIM],
    input  logic [DATA_W-1:0] rdata,
    input  logic              rdata_vld,
    output logic [ADDR_W-1:0] waddr,
    output logic [DATA_W-1:0] wdata,
    output logic              wdata_vld,
    output logic              finish
);

    strided_copy_pkg::wr_state_t state, state_nxt;

    logic [ADDR_W-1:0] beat_cnt;
    logic [ADDR_W-1:0] beat_max;
    logic              last_beat;
    logic [DATA_W-1:0] rdata_q;
    logic [ADDR_W-1:0] gen_addr;
    logic              gen_vld;

    assign last_beat = (state == strided_copy_pkg::WR_RUN) && wdata_vld
                       && (beat_cnt == beat_max - 1'b1);

    always_comb begin
        state_nxt = state;
        if (init_pulse) begin
            state_nxt = (areq_num != '0) ? strided_copy_pkg::WR_RUN : strided_copy_pkg::WR_IDLE;
        end else if (last_beat) begin
            state_nxt = strided_copy_pkg::WR_IDLE;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) state <= strided_copy_pkg::WR_IDLE;
        else          state <= state_nxt;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_cnt <= '0;
            beat_max <= '0;
        end else if (init_pulse) begin
            beat_cnt <= '0;
            beat_max <= areq_num;
        end else if (state == strided_copy_pkg::WR_RUN && wdata_vld) begin
            beat_cnt <= beat_cnt + 1'b1;   // Written beats.
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) finish <= 1'b0;
        else          finish <= last_beat;
    end

    // One write address per returned beat.
    nested_addr_gen #(.ADDR_W(ADDR_W), .ADIM(ADIM)) wr_addr_gen (
        .clk        (clk),
        .reset_n    (reset_n),
        .init_pulse (init_pulse),
        .addr_req   (rdata_vld),
        .base       (waddr_base),
        .size       (waddr_size),
        .stride     (waddr_stride),
        .addr       (gen_addr),
        .addr_vld   (gen_vld)
    );

    // Data stage, lines up with the generator address.
    always_ff @(posedge clk) begin
        if (rdata_vld) rdata_q <= rdata;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            waddr     <= '0;
            wdata     <= '0;
            wdata_vld <= 1'b0;
        end else begin
            wdata_vld <= gen_vld;
            if (gen_vld) begin
                waddr <= gen_addr;
                wdata <= rdata_q;
            end
        end
    end

endmodule : write_sequencer

//--- strided_copy.f
src/strided_copy_pkg.sv
src/nested_addr_gen.sv
src/read_sequencer.sv
src/write_sequencer.sv
src/strided_copy.sv
verif/tb_clock.sv
verif/strided_copy_assert.sv
verif/strided_copy_tb.sv

//--- verif/strided_copy_assert.sv
`timescale 1ns/1ps

module strided_copy_assert #(
    parameter int ADDR_W = strided_copy_pkg::DEF_ADDR_W,
    parameter int ADIM   = strided_copy_pkg::DEF_ADIM,
    parameter int DATA_W = strided_copy_pkg::DEF_DATA_W
) (
    input logic              clk,
    input logic              reset_n,
    input logic              init_pulse,
    input logic [ADDR_W-1:0] areq_num,
    input logic [ADDR_W-1:0] raddr_base,
    input logic [ADDR_W-1:0] raddr_size[ADIM],
    input logic [ADDR_W-1:0] raddr_stride[ADIM],
    input logic [ADDR_W-1:0] waddr_base,
    input logic [ADDR_W-1:0] waddr_size[ADIM],
    input logic [ADDR_W-1:0] waddr_stride[ADIM],
    input logic [ADDR_W-1:0] raddr,
    input logic              raddr_vld,
    input logic [DATA_W-1:0] rdata,
    input logic              rdata_vld,
    input logic [ADDR_W-1:0] waddr,
    input logic [DATA_W-1:0] wdata,
    input logic              wdata_vld,
    input logic              finish
);

    int unsigned       rd_k;
    int unsigned       wr_k;
    logic [ADDR_W-1:0] num_lat;
    logic [ADDR_W-1:0] rd_rem;   // Read beats still expected.
    logic              init_q;
    logic              rv_q1;
    logic              rv_q2;
    logic [DATA_W-1:0] rdat_q1;
    logic [DATA_W-1:0] rdat_q2;
    logic              wr_active;
    logic              exp_finish;
    logic              last_wr;
    logic              exp_rvld;
    logic [ADDR_W-1:0] exp_raddr;
    logic [ADDR_W-1:0] exp_waddr;
    int                err_cnt = 0;

    // Mixed-radix digits of k, dimension 0 fastest.
    function automatic logic [ADDR_W-1:0] addr_at(
        input logic [ADDR_W-1:0] base,
        input logic [ADDR_W-1:0] sz[ADIM],
        input logic [ADDR_W-1:0] st[ADIM],
        input int unsigned       k
    );
        int unsigned       rest;
        logic [ADDR_W-1:0] a;
        rest = k;
        a    = base;
        for (int d = 0; d < ADIM; d++) begin
            a    = a + ADDR_W'((rest % sz[d]) * st[d]);
            rest = rest / sz[d];   // Leftover quotient is the wrap.
        end
        return a;
    endfunction

    task automatic flag_mismatch(
        input string             name,
        input logic [DATA_W-1:0] exp_v,
        input logic [DATA_W-1:0] got_v
    );
        err_cnt = err_cnt + 1;
        $error("[FAIL] t=%0t %s exp=%0h got=%0h", $time, name, exp_v, got_v);
    endtask

    assign exp_rvld  = (rd_rem != '0);
    assign last_wr   = wr_active && wdata_vld && (wr_k + 1 == int'(num_lat));
    assign exp_raddr = addr_at(raddr_base, raddr_size, raddr_stride, rd_k);
    assign exp_waddr = addr_at(waddr_base, waddr_size, waddr_stride, wr_k);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_k       <= 0;
            wr_k       <= 0;
            num_lat    <= '0;
            rd_rem     <= '0;
            init_q     <= 1'b0;
            rv_q1      <= 1'b0;
            rv_q2      <= 1'b0;
            rdat_q1    <= '0;
            rdat_q2    <= '0;
            wr_active  <= 1'b0;
            exp_finish <= 1'b0;
        end else begin
            init_q     <= init_pulse;
            rv_q1      <= rdata_vld;
            rv_q2      <= rv_q1;
            rdat_q1    <= rdata;
            rdat_q2    <= rdat_q1;
            exp_finish <= last_wr;
            if (init_pulse) begin
                num_lat   <= areq_num;
                rd_k      <= 0;
                wr_k      <= 0;
                wr_active <= (areq_num != '0);
            end else begin
                if (raddr_vld) rd_k <= rd_k + 1;
                if (wdata_vld) wr_k <= wr_k + 1;
                if (last_wr) wr_active <= 1'b0;
            end
            if (init_q) rd_rem <= num_lat;   // Reads begin two cycles after init.
            else if (rd_rem != '0) rd_rem <= rd_rem - 1'b1;
        end
    end

    a_raddr_vld: assert property (@(posedge clk) disable iff (!reset_n)
        raddr_vld == exp_rvld)
        else flag_mismatch("raddr_vld", $sampled(exp_rvld), $sampled(raddr_vld));
    a_raddr: assert property (@(posedge clk) disable iff (!reset_n)
        raddr_vld |-> raddr == exp_raddr)
        else flag_mismatch("raddr", $sampled(exp_raddr), $sampled(raddr));
    a_wdata_vld: assert property (@(posedge clk) disable iff (!reset_n)
        wdata_vld == rv_q2)
        else flag_mismatch("wdata_vld", $sampled(rv_q2), $sampled(wdata_vld));
    a_wdata: assert property (@(posedge clk) disable iff (!reset_n)
        wdata_vld |-> wdata == rdat_q2)
        else flag_mismatch("wdata", $sampled(rdat_q2), $sampled(wdata));
    a_waddr: assert property (@(posedge clk) disable iff (!reset_n)
        wdata_vld |-> waddr == exp_waddr)
        else flag_mismatch("waddr", $sampled(exp_waddr), $sampled(waddr));
    a_finish: assert property (@(posedge clk) disable iff (!reset_n)
        finish == exp_finish)
        else flag_mismatch("finish", $sampled(exp_finish), $sampled(finish));

endmodule : strided_copy_assert

//--- verif/strided_copy_tb.sv
`timescale 1ns/1ps

module strided_copy_tb;

    localparam int ADDR_W  = 16;
    localparam int ADIM    = 3;
    localparam int DATA_W  = 64;
    localparam int TIMEOUT = 400;   // Cycles per wait.

    logic              clk;
    logic              reset_n;
    logic              init_pulse;
    logic [ADDR_W-1:0] areq_num;
    logic [ADDR_W-1:0] raddr_base;
    logic [ADDR_W-1:0] raddr_size[ADIM];
    logic [ADDR_W-1:0] raddr_stride[ADIM];
    logic [ADDR_W-1:0] waddr_base;
    logic [ADDR_W-1:0] waddr_size[ADIM];
    logic [ADDR_W-1:0] waddr_stride[ADIM];
    logic [ADDR_W-1:0] raddr;
    logic              raddr_vld;
    logic [DATA_W-1:0] rdata;
    logic              rdata_vld;
    logic [ADDR_W-1:0] waddr;
    logic [DATA_W-1:0] wdata;
    logic              wdata_vld;
    logic              finish;
    logic [31:0]       lfsr;

    tb_clock clock0 (.clk(clk), .reset_n(reset_n));

    strided_copy #(.ADDR_W(ADDR_W), .ADIM(ADIM), .DATA_W(DATA_W)) dut0 (.*);

    bind strided_copy strided_copy_assert #(
        .ADDR_W(ADDR_W), .ADIM(ADIM), .DATA_W(DATA_W)
    ) u_assert (.*);

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic wait_reset_release();
        int cyc = 0;
        while (!reset_n) begin
            @(negedge clk);
            cyc++;
            if (cyc > TIMEOUT) stop_on_error("Timeout: reset_n was never released");
        end
    endtask

    task automatic wait_reads_done();
        int cyc  = 0;
        bit seen = 1'b0;
        while (!(seen && !raddr_vld)) begin
            @(negedge clk);
            if (raddr_vld) seen = 1'b1;
            cyc++;
            if (cyc > TIMEOUT) stop_on_error("Timeout: read addresses did not run and end");
        end
    endtask

    task automatic wait_finish();
        int cyc = 0;
        while (!finish) begin
            @(negedge clk);
            cyc++;
            if (cyc > TIMEOUT) stop_on_error("Timeout: finish pulse never seen");
        end
    endtask

    // Returned beats with 1 to 3 idle cycles between them.
    task automatic send_beats(input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            rdata     = rand_bits(DATA_W);
            rdata_vld = 1'b1;
            @(negedge clk);
            rdata_vld = 1'b0;
            if (i < n - 1) begin
                gap = 1 + int'(rand_bits(2) % 3);
                repeat (gap) @(negedge clk);
            end
        end
    endtask

    task automatic run_copy(input logic [ADDR_W-1:0] n);
        areq_num   = n;
        init_pulse = 1'b1;
        @(negedge clk);
        init_pulse = 1'b0;
        wait_reads_done();
        send_beats(n);
        wait_finish();
        repeat (4) @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (dut0.u_assert.err_cnt != 0) stop_on_error("An assertion reported a mismatch");
    end

    initial begin
        lfsr         = 32'd32;
        init_pulse   = 1'b0;
        areq_num     = '0;
        raddr_base   = '0;
        waddr_base   = '0;
        raddr_size   = '{default: 16'd1};
        raddr_stride = '{default: 16'd0};
        waddr_size   = '{default: 16'd1};
        waddr_stride = '{default: 16'd0};
        rdata        = '0;
        rdata_vld    = 1'b0;
        wait_reset_release();
        repeat (5) @(negedge clk);   // Quiet outputs before any init.

        // Dimension 0 wraps on both sides and the write pattern wraps fully.
        raddr_size   = '{16'd4, 16'd3, 16'd2};
        raddr_stride = '{16'd1, 16'd16, 16'd64};
        waddr_size   = '{16'd2, 16'd2, 16'd2};
        waddr_stride = '{16'd4, 16'd32, 16'd256};
        run_copy(16'd10);

        // New bases restart both sequences at index zero.
        raddr_base   = 16'h1000;
        waddr_base   = 16'h8000;
        raddr_size   = '{16'd5, 16'd2, 16'd3};
        raddr_stride = '{16'd2, 16'd40, 16'd200};
        waddr_size   = '{16'd3, 16'd4, 16'd2};
        waddr_stride = '{16'd8, 16'd1, 16'd512};
        run_copy(16'd17);

        if (dut0.u_assert.err_cnt == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "assertion errors were recorded");
        end
    end

endmodule : strided_copy_tb

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD      = 20,
    parameter int RESET_TICKS = 4
) (
    output logic clk,
    output logic reset_n
);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    initial begin
        reset_n = 1'b0;
        repeat (RESET_TICKS) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;   // Released on a falling edge.
    end

endmodule : tb_clock
